//--- verilog/conv_pkg.sv
package conv_pkg;

  // grid geometry
  localparam int ARRAY_HEIGHT = 4;  // pe rows, words per ifmap vector
  localparam int ARRAY_WIDTH  = 4;  // pe columns, results per ofmap vector

  localparam int IFMAP_WIDTH  = 16;
  localparam int WEIGHT_WIDTH = 16;
  localparam int OFMAP_WIDTH  = 32;

  localparam int BANK_DEPTH   = 8;  // vectors per ifmap bank

  localparam int NUM_WEIGHTS  = ARRAY_HEIGHT * ARRAY_WIDTH;
  // skew plus grid plus deskew plus output register
  localparam int PIPE_LATENCY = ARRAY_HEIGHT + ARRAY_WIDTH;

  // scalar words, all signed
  typedef logic signed [IFMAP_WIDTH-1:0]  ifmap_word_t;
  typedef logic signed [WEIGHT_WIDTH-1:0] weight_word_t;
  typedef logic signed [OFMAP_WIDTH-1:0]  ofmap_word_t;

  // row 0 / column 0 in the low bits
  typedef logic [ARRAY_HEIGHT*IFMAP_WIDTH-1:0] ifmap_vec_t;
  typedef logic [ARRAY_WIDTH*OFMAP_WIDTH-1:0]  ofmap_vec_t;

  typedef logic [$clog2(BANK_DEPTH)-1:0]   bank_addr_t;
  typedef logic [$clog2(NUM_WEIGHTS)-1:0]  weight_idx_t;
  typedef logic [$clog2(ARRAY_HEIGHT)-1:0] word_idx_t;  // slot inside a vector

  typedef enum logic {
    RD_IDLE,
    RD_STREAM
  } rd_state_t;

endpackage

//--- verilog/ifmap_packer.sv
module ifmap_packer
  import conv_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  ifmap_word_t ifmap_dat,
  input  logic        ifmap_vld,

  output logic        wen,
  output bank_addr_t  wadr,
  output ifmap_vec_t  wdata,
  output logic        switch_banks
);

  word_idx_t  word_cnt;
  ifmap_vec_t vec_q;
  bank_addr_t wr_ptr;
  logic       last_word;

  // strobe that completes a vector
  assign last_word = ifmap_vld && (word_cnt == word_idx_t'(ARRAY_HEIGHT - 1));

  // drop each word into its row slot
  always_ff @(posedge clk) begin
    if (ifmap_vld) begin
      vec_q[word_cnt*IFMAP_WIDTH +: IFMAP_WIDTH] <= ifmap_dat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt     <= '0;
      wen          <= 1'b0;
      switch_banks <= 1'b0;
      wr_ptr       <= '0;
    end else begin
      wen          <= last_word;
      // buffer swaps on the write to the last slot
      switch_banks <= last_word && (wr_ptr == bank_addr_t'(BANK_DEPTH - 1));

      if (ifmap_vld) begin
        if (last_word) begin
          word_cnt <= '0;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end

      if (wen) begin  // advance after the write lands
        if (wr_ptr == bank_addr_t'(BANK_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  assign wadr  = wr_ptr;
  assign wdata = vec_q;  // complete during the wen cycle

  a_switch_with_wen: assert property (
    @(posedge clk) disable iff (!rst_n)
    switch_banks == (wen && (wadr == bank_addr_t'(BANK_DEPTH - 1)))
  ) else $error("switch_banks out of step with the write to the last address");

endmodule

//--- verilog/ifmap_double_buffer.sv
module ifmap_double_buffer
  import conv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // write side, from the packer
  input  logic       wen,
  input  bank_addr_t wadr,
  input  ifmap_vec_t wdata,
  input  logic       switch_banks,

  // read side, to the array
  output logic       vec_vld,
  output ifmap_vec_t vec_dat
);

  ifmap_vec_t bank_mem [2][BANK_DEPTH];

  logic       wr_bank;  // bank being filled
  logic       rd_bank;
  bank_addr_t radr;
  rd_state_t  rd_state;

  assign rd_bank = ~wr_bank;  // the other one is the full one

  always_ff @(posedge clk) begin
    if (wen) begin
      bank_mem[wr_bank][wadr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bank <= 1'b0;
    end else if (switch_banks) begin
      wr_bank <= ~wr_bank;
    end
  end

  // walk the full bank once per swap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= RD_IDLE;
      radr     <= '0;
      vec_vld  <= 1'b0;
    end else begin
      vec_vld <= (rd_state == RD_STREAM);  // one cycle behind the address
      case (rd_state)
        RD_IDLE: begin
          if (switch_banks) begin
            rd_state <= RD_STREAM;
            radr     <= '0;
          end
        end
        RD_STREAM: begin
          radr <= radr + 1'b1;
          if (radr == bank_addr_t'(BANK_DEPTH - 1)) begin
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // registered read data
  always_ff @(posedge clk) begin
    if (rd_state == RD_STREAM) begin
      vec_dat <= bank_mem[rd_bank][radr];
    end
  end

  // a new swap while streaming would overwrite the bank being read
  a_no_overrun: assert property (
    @(posedge clk) disable iff (!rst_n)
    switch_banks |-> (rd_state != RD_STREAM)
  ) else $error("bank swap while the previous bank is still streaming");

endmodule

//--- verilog/mac_pe.sv
module mac_pe
  import conv_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  input  logic         weight_load,
  input  weight_word_t weight_in,

  input  ifmap_word_t  act_in,
  input  logic         act_vld_in,
  input  ofmap_word_t  psum_in,

  output ifmap_word_t  act_out,
  output logic         act_vld_out,
  output ofmap_word_t  psum_out
);

  weight_word_t weight_q;  // stationary
  ofmap_word_t  product;

  // sign extend first, keep the low result bits
  assign product = ofmap_word_t'(act_in) * ofmap_word_t'(weight_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_q <= '0;
    end else if (weight_load) begin
      weight_q <= weight_in;
    end
  end

  always_ff @(posedge clk) begin
    act_out <= act_in;  // on to the next column
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      act_vld_out <= 1'b0;
      psum_out    <= '0;
    end else begin
      act_vld_out <= act_vld_in;
      if (act_vld_in) begin
        psum_out <= psum_in + product;
      end else begin
        psum_out <= psum_in;  // bubble, pass through
      end
    end
  end

endmodule

//--- verilog/systolic_array.sv
module systolic_array
  import conv_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  input  weight_word_t weights_dat,
  input  logic         weights_vld,

  input  logic         vec_vld,
  input  ifmap_vec_t   vec_dat,

  output logic         ofmap_vld,
  output ofmap_vec_t   ofmap_dat
);

  weight_idx_t             widx;
  logic [PIPE_LATENCY-1:0] vld_pipe;

  // activations move right, partial sums move down
  ifmap_word_t act_h  [ARRAY_HEIGHT][ARRAY_WIDTH+1];
  logic        vld_h  [ARRAY_HEIGHT][ARRAY_WIDTH+1];
  ofmap_word_t psum_v [ARRAY_HEIGHT+1][ARRAY_WIDTH];
  ofmap_word_t col_aligned [ARRAY_WIDTH];

  // k-th weight goes to row k / width, column k % width
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      widx <= '0;
    end else if (weights_vld) begin
      if (widx == weight_idx_t'(NUM_WEIGHTS - 1)) begin
        widx <= '0;
      end else begin
        widx <= widx + 1'b1;
      end
    end
  end

  // input skew, row i late by i cycles
  for (genvar i = 0; i < ARRAY_HEIGHT; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign act_h[0][0] = vec_dat[IFMAP_WIDTH-1:0];
      assign vld_h[0][0] = vec_vld;
    end else begin : g_delay
      ifmap_word_t  act_dly [i];
      logic [i-1:0] vld_dly;

      always_ff @(posedge clk) begin
        act_dly[0] <= vec_dat[i*IFMAP_WIDTH +: IFMAP_WIDTH];
        for (int k = 1; k < i; k++) begin
          act_dly[k] <= act_dly[k-1];
        end
      end

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          vld_dly <= '0;
        end else begin
          vld_dly[0] <= vec_vld;
          for (int k = 1; k < i; k++) begin
            vld_dly[k] <= vld_dly[k-1];
          end
        end
      end

      assign act_h[i][0] = act_dly[i-1];
      assign vld_h[i][0] = vld_dly[i-1];
    end
  end

  for (genvar i = 0; i < ARRAY_HEIGHT; i++) begin : g_row
    for (genvar j = 0; j < ARRAY_WIDTH; j++) begin : g_col
      mac_pe u_pe (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_load (weights_vld && (widx == weight_idx_t'(i*ARRAY_WIDTH + j))),
        .weight_in   (weights_dat),
        .act_in      (act_h[i][j]),
        .act_vld_in  (vld_h[i][j]),
        .psum_in     (psum_v[i][j]),
        .act_out     (act_h[i][j+1]),
        .act_vld_out (vld_h[i][j+1]),
        .psum_out    (psum_v[i+1][j])
      );
    end
  end

  // output deskew, column j late by width-1-j
  for (genvar j = 0; j < ARRAY_WIDTH; j++) begin : g_deskew
    assign psum_v[0][j] = '0;
    if (j == ARRAY_WIDTH - 1) begin : g_direct
      assign col_aligned[j] = psum_v[ARRAY_HEIGHT][j];
    end else begin : g_delay
      ofmap_word_t psum_dly [ARRAY_WIDTH-1-j];

      always_ff @(posedge clk) begin
        psum_dly[0] <= psum_v[ARRAY_HEIGHT][j];
        for (int k = 1; k < ARRAY_WIDTH - 1 - j; k++) begin
          psum_dly[k] <= psum_dly[k-1];
        end
      end

      assign col_aligned[j] = psum_dly[ARRAY_WIDTH-2-j];
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < ARRAY_WIDTH; j++) begin
      ofmap_dat[j*OFMAP_WIDTH +: OFMAP_WIDTH] <= col_aligned[j];
    end
  end

  // one bit per vector in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[PIPE_LATENCY-2:0], vec_vld};
    end
  end

  assign ofmap_vld = vld_pipe[PIPE_LATENCY-1];

  // a reload mid-flight would mix two weight sets in one result
  a_no_reload_in_flight: assert property (
    @(posedge clk) disable iff (!rst_n)
    weights_vld |-> !(vec_vld || (|vld_pipe))
  ) else $error("weights loaded while vectors are in the array");

endmodule

//--- verilog/conv_top.sv
module conv_top
  import conv_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  // activation words
  input  ifmap_word_t  ifmap_dat,
  input  logic         ifmap_vld,

  // weight words, row-major
  input  weight_word_t weights_dat,
  input  logic         weights_vld,

  // one result vector per strobe
  output ofmap_vec_t   ofmap_dat,
  output logic         ofmap_vld
);

  logic       buf_wen;
  bank_addr_t buf_wadr;
  ifmap_vec_t buf_wdata;
  logic       buf_switch;

  logic       vec_vld;
  ifmap_vec_t vec_dat;

  ifmap_packer u_packer (
    .clk          (clk),
    .rst_n        (rst_n),
    .ifmap_dat    (ifmap_dat),
    .ifmap_vld    (ifmap_vld),
    .wen          (buf_wen),
    .wadr         (buf_wadr),
    .wdata        (buf_wdata),
    .switch_banks (buf_switch)
  );

  ifmap_double_buffer u_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .wen          (buf_wen),
    .wadr         (buf_wadr),
    .wdata        (buf_wdata),
    .switch_banks (buf_switch),
    .vec_vld      (vec_vld),
    .vec_dat      (vec_dat)
  );

  systolic_array u_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .vec_vld     (vec_vld),
    .vec_dat     (vec_dat),
    .ofmap_vld   (ofmap_vld),
    .ofmap_dat   (ofmap_dat)
  );

endmodule

//--- tests/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// slot row*ARRAY_WIDTH+col holds weight(row, col)
typedef logic [NUM_WEIGHTS*WEIGHT_WIDTH-1:0] weight_grid_t;

function automatic int weight_row(input int k);
  return k / ARRAY_WIDTH;
endfunction

function automatic int weight_col(input int k);
  return k % ARRAY_WIDTH;
endfunction

// k-th word of a weight stream
function automatic weight_grid_t place_weight(input weight_grid_t grid, input int k,
                                              input weight_word_t w);
  int slot;
  slot = weight_row(k) * ARRAY_WIDTH + weight_col(k);
  grid[slot*WEIGHT_WIDTH +: WEIGHT_WIDTH] = w;
  return grid;
endfunction

function automatic weight_word_t weight_at(input weight_grid_t grid, input int row,
                                           input int col);
  return grid[(row*ARRAY_WIDTH + col)*WEIGHT_WIDTH +: WEIGHT_WIDTH];
endfunction

// wide accumulate, then keep the low 32 bits
function automatic ofmap_word_t column_dot(input ifmap_vec_t vec, input weight_grid_t grid,
                                           input int col);
  longint       acc;
  ifmap_word_t  a;
  weight_word_t w;
  acc = 0;
  for (int i = 0; i < ARRAY_HEIGHT; i++) begin
    a = vec[i*IFMAP_WIDTH +: IFMAP_WIDTH];
    w = weight_at(grid, i, col);
    acc += longint'(a) * longint'(w);
  end
  return ofmap_word_t'(acc);
endfunction

function automatic ofmap_vec_t expected_vector(input ifmap_vec_t vec, input weight_grid_t grid);
  ofmap_vec_t res;
  for (int j = 0; j < ARRAY_WIDTH; j++) begin
    res[j*OFMAP_WIDTH +: OFMAP_WIDTH] = column_dot(vec, grid, j);
  end
  return res;
endfunction

`endif

//--- tests/conv_tb.sv
module conv_tb
  import conv_pkg::*;
();

  logic         clk;
  logic         rst_n;
  ifmap_word_t  ifmap_dat;
  logic         ifmap_vld;
  weight_word_t weights_dat;
  logic         weights_vld;
  ofmap_vec_t   ofmap_dat;
  logic         ofmap_vld;

  `include "conv_model.svh"

  ofmap_vec_t   exp_q [$];
  ofmap_vec_t   exp_head = '0;
  logic         exp_pending = 1'b0;
  logic         quiet = 1'b1;  // no result may appear while set

  weight_grid_t model_grid = '0;
  int           model_widx = 0;
  int           model_slot = 0;
  ifmap_vec_t   model_vec = '0;
  weight_word_t wset [NUM_WEIGHTS];

  int value_errors = 0;
  int proto_errors = 0;

  conv_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .ifmap_dat   (ifmap_dat),
    .ifmap_vld   (ifmap_vld),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .ofmap_dat   (ofmap_dat),
    .ofmap_vld   (ofmap_vld)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // mirrors the input strobes, head/pending settle one edge later
  always @(posedge clk) begin
    if (weights_vld) begin
      model_grid = place_weight(model_grid, model_widx, weights_dat);
      model_widx = (model_widx + 1) % NUM_WEIGHTS;
    end
    if (ifmap_vld) begin
      model_vec[model_slot*IFMAP_WIDTH +: IFMAP_WIDTH] = ifmap_dat;
      if (model_slot == ARRAY_HEIGHT - 1) begin
        exp_q.push_back(expected_vector(model_vec, model_grid));
        model_slot = 0;
      end else begin
        model_slot++;
      end
    end
    if (ofmap_vld && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    exp_pending <= (exp_q.size() != 0);
    exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  a_ofmap_owed: assert property (
    @(posedge clk) disable iff (!rst_n)
    ofmap_vld |-> exp_pending
  ) else begin
    proto_errors++;
    $display("ofmap_vld raised with no input vector outstanding");
  end

  a_ofmap_value: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ofmap_vld && exp_pending) |-> (ofmap_dat == exp_head)
  ) else begin
    value_errors++;
    $display("CHECK FAILED ofmap_dat expected %h got %h", $sampled(exp_head),
             $sampled(ofmap_dat));
  end

  a_quiet: assert property (
    @(posedge clk) disable iff (!rst_n)
    quiet |-> !ofmap_vld
  ) else begin
    proto_errors++;
    $display("ofmap_vld raised while no result was due");
  end

  function automatic logic [15:0] extreme_word();
    return ($urandom_range(0, 1) == 1) ? 16'h8000 : 16'h7fff;
  endfunction

  task automatic pick_weights(input bit extremes);
    for (int k = 0; k < NUM_WEIGHTS; k++) begin
      wset[k] = extremes ? weight_word_t'(extreme_word()) : weight_word_t'($urandom);
    end
  endtask

  task automatic load_weights();
    for (int k = 0; k < NUM_WEIGHTS; k++) begin
      @(posedge clk);
      weights_vld <= 1'b1;
      weights_dat <= wset[k];
    end
    @(posedge clk);
    weights_vld <= 1'b0;
  endtask

  task automatic send_word(input ifmap_word_t w, input bit gaps);
    int gap;
    @(posedge clk);
    ifmap_vld <= 1'b1;
    ifmap_dat <= w;
    gap = gaps ? $urandom_range(0, 3) : 0;
    for (int g = 0; g < gap; g++) begin
      @(posedge clk);
      ifmap_vld <= 1'b0;
    end
  endtask

  task automatic send_vectors(input int n, input bit extremes, input bit gaps);
    ifmap_word_t w;
    for (int v = 0; v < n; v++) begin
      for (int i = 0; i < ARRAY_HEIGHT; i++) begin
        w = extremes ? ifmap_word_t'(extreme_word()) : ifmap_word_t'($urandom);
        send_word(w, gaps);
      end
    end
    @(posedge clk);
    ifmap_vld <= 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (exp_pending && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_pending) begin
      proto_errors++;
      $display("timeout after %0d cycles, %0d ofmap vectors never arrived", limit,
               exp_q.size());
    end
  endtask

  // hold quiet for a while, catches extra or early results
  task automatic idle_quiet(input int n);
    @(posedge clk);
    quiet <= 1'b1;
    for (int c = 0; c < n; c++) begin
      @(posedge clk);
    end
  endtask

  initial begin
    int seed_sink;
    seed_sink = $urandom(32'h76d85026);
    rst_n       = 1'b0;
    ifmap_dat   = '0;
    ifmap_vld   = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    for (int c = 0; c < 8; c++) begin
      @(posedge clk);
    end
    rst_n <= 1'b1;

    pick_weights(1'b0);
    load_weights();
    send_vectors(BANK_DEPTH - 1, 1'b0, 1'b1);
    quiet <= 1'b0;  // last vector completes the bank
    send_vectors(1, 1'b0, 1'b1);
    wait_drain(100);
    idle_quiet(20);

    // two banks back to back
    quiet <= 1'b0;
    send_vectors(2 * BANK_DEPTH, 1'b0, 1'b1);
    wait_drain(100);
    idle_quiet(20);

    // partial bank stays parked in the buffer
    send_vectors(5, 1'b0, 1'b1);
    idle_quiet(60);
    quiet <= 1'b0;
    send_vectors(BANK_DEPTH - 5, 1'b0, 1'b1);
    wait_drain(100);
    idle_quiet(20);

    pick_weights(1'b0);
    load_weights();
    quiet <= 1'b0;
    send_vectors(BANK_DEPTH, 1'b0, 1'b1);
    wait_drain(100);
    idle_quiet(20);

    // full-scale operands, sums wrap at 32 bits
    pick_weights(1'b1);
    load_weights();
    quiet <= 1'b0;
    send_vectors(BANK_DEPTH, 1'b1, 1'b1);
    wait_drain(100);
    idle_quiet(20);

    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+tests
verilog/conv_pkg.sv
verilog/ifmap_packer.sv
verilog/ifmap_double_buffer.sv
verilog/mac_pe.sv
verilog/systolic_array.sv
verilog/conv_top.sv
tests/conv_tb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_tb -Mdir "$build_dir" -o conv_sim -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/conv_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST OK$" "$log_file"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail, see $log_file"
exit 1
